// ==== rx_mac_pkg.sv ====
package rx_mac_pkg;

	typedef logic [63:0] xgmii_data_t;	// lane 0 in bits 7:0
	typedef logic [7:0] xgmii_ctrl_t;	// one bit per lane
	typedef logic [31:0] stat_cnt_t;	// wraps
	typedef logic [3:0] wb_addr_t;	// word address
	typedef logic [31:0] wb_data_t;
	typedef logic [15:0] frame_len_t;	// data lanes of one frame
	typedef logic [4:0] link_cnt_t;

	typedef enum logic [1:0]
	{
		IDLE,
		IN_FRAME,
		FAULTED
	} frame_state_t;

	localparam logic [7:0] XGMII_START = 8'hFB;
	localparam logic [7:0] XGMII_TERM = 8'hFD;
	localparam logic [7:0] XGMII_IDLE = 8'h07;
	localparam logic [7:0] XGMII_FAULT = 8'h9C;	// sequence char, lane 0 only

	localparam link_cnt_t LINK_UP_CYCLES = 5'd16;	// clean words before link-up
	localparam frame_len_t UNDERSIZE_LEN = 16'd71;	// 64 bytes + preamble and SFD

	localparam wb_addr_t REG_FRAME_CNT = 4'd0;
	localparam wb_addr_t REG_BAD_SOF_CNT = 4'd1;
	localparam wb_addr_t REG_BYTE_CNT = 4'd2;
	localparam wb_addr_t REG_UNDERSIZE_CNT = 4'd3;
	localparam wb_addr_t REG_STATUS = 4'd4;
	localparam int CLEAR_BIT = 0;	// write bit at REG_FRAME_CNT

	// per-lane mask of control lanes holding character ch
	function automatic xgmii_ctrl_t lane_match(input xgmii_data_t d, input xgmii_ctrl_t c,
		input logic [7:0] ch);
		xgmii_ctrl_t m;
		for (int i = 0; i < 8; i++)
		begin
			m[i] = c[i] && (d[8*i +: 8] == ch);
		end
		return m;
	endfunction

endpackage

// ==== rx_lane_if.sv ====
interface rx_lane_if
	import rx_mac_pkg::*;
();

	xgmii_data_t data;	// aligned word
	xgmii_ctrl_t ctrl;
	logic sof;	// start sits in lane 0
	logic linkup;

	modport source
	(
		output data, ctrl, sof, linkup
	);

	modport sink
	(
		input data, ctrl, sof, linkup
	);

endinterface

// ==== stat_if.sv ====
interface stat_if
	import rx_mac_pkg::*;
();

	stat_cnt_t frame_cnt;
	stat_cnt_t bad_sof_cnt;
	stat_cnt_t byte_cnt;
	stat_cnt_t undersize_cnt;
	logic linkup;
	logic clear;	// one-cycle strobe from host write

	modport producer
	(
		output frame_cnt, bad_sof_cnt, byte_cnt, undersize_cnt, linkup,
		input clear
	);

	modport consumer
	(
		input frame_cnt, bad_sof_cnt, byte_cnt, undersize_cnt, linkup,
		output clear
	);

endinterface

// ==== xgmii_rx_align.sv ====
module xgmii_rx_align
	import rx_mac_pkg::*;
(
	input logic clk,
	input logic reset_,
	input xgmii_data_t xgmii_rxd,
	input xgmii_ctrl_t xgmii_rxc,
	rx_lane_if.source lane
);

	xgmii_data_t rxd_q;	// first stage whose upper half is the earlier word
	xgmii_ctrl_t rxc_q;
	xgmii_data_t data_q;	// output stage
	xgmii_ctrl_t ctrl_q;
	logic sof_q;
	logic shifted;	// inside a frame that began in lane 4
	logic drop_lo;	// lower half already sent in last shifted word
	logic shift_now;
	logic start_lane4;
	logic term_nxt;
	logic sof_nxt;
	logic fault_word;
	xgmii_ctrl_t start_q;	// start lanes of the first stage
	xgmii_ctrl_t fault_q;
	xgmii_ctrl_t start_nxt;
	xgmii_data_t data_nxt;
	xgmii_ctrl_t ctrl_nxt;
	link_cnt_t link_cnt;

	assign start_q = lane_match(rxd_q, rxc_q, XGMII_START);
	assign fault_q = lane_match(rxd_q, rxc_q, XGMII_FAULT);
	assign start_lane4 = start_q[4];
	assign fault_word = fault_q[0];
	assign shift_now = shifted || start_lane4;

	always_comb
	begin
		if (shift_now)
		begin
			data_nxt = {xgmii_rxd[31:0], rxd_q[63:32]};	// earlier upper + current lower
			ctrl_nxt = {xgmii_rxc[3:0], rxc_q[7:4]};
		end
		else if (drop_lo)
		begin
			data_nxt = {rxd_q[63:32], {4{XGMII_IDLE}}};
			ctrl_nxt = {rxc_q[7:4], 4'hF};
		end
		else
		begin
			data_nxt = rxd_q;
			ctrl_nxt = rxc_q;
		end
	end

	assign term_nxt = |lane_match(data_nxt, ctrl_nxt, XGMII_TERM);
	assign start_nxt = lane_match(data_nxt, ctrl_nxt, XGMII_START);
	assign sof_nxt = start_nxt[0];

	always_ff @(posedge clk)
	begin
		if (!reset_)
		begin
			rxd_q <= {8{XGMII_IDLE}};
			rxc_q <= '1;
			data_q <= {8{XGMII_IDLE}};
			ctrl_q <= '1;	// all idle out of reset
			sof_q <= 1'b0;
			shifted <= 1'b0;
			drop_lo <= 1'b0;
		end
		else
		begin
			rxd_q <= xgmii_rxd;
			rxc_q <= xgmii_rxc;
			data_q <= data_nxt;
			ctrl_q <= ctrl_nxt;
			sof_q <= sof_nxt;
			shifted <= shift_now && !term_nxt;	// leave once terminate is out
			drop_lo <= shift_now && term_nxt;
		end
	end

	// any fault word restarts link qualification
	always_ff @(posedge clk)
	begin
		if (!reset_ || fault_word)
			link_cnt <= '0;
		else if (link_cnt != LINK_UP_CYCLES)
			link_cnt <= link_cnt + 1'b1;
	end

	assign lane.data = data_q;
	assign lane.ctrl = ctrl_q;
	assign lane.sof = sof_q;
	assign lane.linkup = (link_cnt == LINK_UP_CYCLES);

endmodule

// ==== frame_stats.sv ====
module frame_stats
	import rx_mac_pkg::*;
(
	input logic clk,
	input logic reset_,
	rx_lane_if.sink lane,
	stat_if.producer stats
);

	frame_state_t state;
	frame_len_t frame_len;	// data lanes so far
	frame_len_t total_len;	// including the current word
	xgmii_ctrl_t start_lanes;
	xgmii_ctrl_t term_lanes;
	logic bad_sof;
	logic bad_sof_inc;
	logic frame_end;
	stat_cnt_t frame_cnt;
	stat_cnt_t bad_sof_cnt;
	stat_cnt_t byte_cnt;
	stat_cnt_t undersize_cnt;

	function automatic frame_len_t data_lanes(input xgmii_ctrl_t c);
		frame_len_t n;
		n = '0;
		for (int i = 0; i < 8; i++)
		begin
			n = n + frame_len_t'(!c[i]);
		end
		return n;
	endfunction

	assign start_lanes = lane_match(lane.data, lane.ctrl, XGMII_START);
	assign term_lanes = lane_match(lane.data, lane.ctrl, XGMII_TERM);
	assign bad_sof = |start_lanes[7:1];	// anything but lane 0
	assign total_len = frame_len + data_lanes(lane.ctrl);
	assign bad_sof_inc = lane.linkup && bad_sof && (state != FAULTED);
	assign frame_end = (state == IN_FRAME) && lane.linkup && !bad_sof && (|term_lanes);

	always_ff @(posedge clk)
	begin
		if (!reset_)
		begin
			state <= IDLE;
			frame_len <= '0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					if (lane.linkup && bad_sof)
						state <= FAULTED;
					else if (lane.linkup && lane.sof)
					begin
						state <= IN_FRAME;
						frame_len <= data_lanes(lane.ctrl);	// preamble lanes of sof word
					end
				end
				IN_FRAME:
				begin
					if (!lane.linkup || bad_sof)
						state <= FAULTED;	// drop the frame
					else if (|term_lanes)
						state <= IDLE;
					else
						frame_len <= total_len;
				end
				FAULTED:
				begin
					if (|term_lanes)
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// clear has priority over any count in the same cycle
	always_ff @(posedge clk)
	begin
		if (!reset_ || stats.clear)
		begin
			frame_cnt <= '0;
			bad_sof_cnt <= '0;
			byte_cnt <= '0;
			undersize_cnt <= '0;
		end
		else
		begin
			if (frame_end)
			begin
				frame_cnt <= frame_cnt + 1'b1;
				byte_cnt <= byte_cnt + stat_cnt_t'(total_len);
				if (total_len < UNDERSIZE_LEN)
					undersize_cnt <= undersize_cnt + 1'b1;
			end
			if (bad_sof_inc)
				bad_sof_cnt <= bad_sof_cnt + 1'b1;
		end
	end

	assign stats.frame_cnt = frame_cnt;
	assign stats.bad_sof_cnt = bad_sof_cnt;
	assign stats.byte_cnt = byte_cnt;
	assign stats.undersize_cnt = undersize_cnt;
	assign stats.linkup = lane.linkup;

endmodule

// ==== stat_regs.sv ====
module stat_regs
	import rx_mac_pkg::*;
(
	input logic clk,
	input logic reset_,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input wb_addr_t wb_adr,
	input wb_data_t wb_dat_w,
	output wb_data_t wb_dat_r,
	output logic wb_ack,
	stat_if.consumer stats
);

	logic req;	// first cycle of an access
	logic clear_q;
	wb_data_t rd_mux;

	assign req = wb_cyc && wb_stb && !wb_ack;

	always_comb
	begin
		case (wb_adr)
			REG_FRAME_CNT: rd_mux = stats.frame_cnt;
			REG_BAD_SOF_CNT: rd_mux = stats.bad_sof_cnt;
			REG_BYTE_CNT: rd_mux = stats.byte_cnt;
			REG_UNDERSIZE_CNT: rd_mux = stats.undersize_cnt;
			REG_STATUS: rd_mux = {31'b0, stats.linkup};
			default: rd_mux = '0;	// unmapped
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!reset_)
		begin
			wb_ack <= 1'b0;
			clear_q <= 1'b0;
		end
		else
		begin
			wb_ack <= req;	// single-cycle ack
			clear_q <= req && wb_we && (wb_adr == REG_FRAME_CNT) && wb_dat_w[CLEAR_BIT];
		end
	end

	always_ff @(posedge clk)
	begin
		if (req)
			wb_dat_r <= rd_mux;	// valid with ack
	end

	assign stats.clear = clear_q;

endmodule

// ==== rx_mac_top.sv ====
module rx_mac_top
	import rx_mac_pkg::*;
(
	input logic clk,
	input logic reset_,
	input xgmii_data_t xgmii_rxd,
	input xgmii_ctrl_t xgmii_rxc,
	output xgmii_data_t rx_data,
	output xgmii_ctrl_t rx_ctrl,
	output logic rx_sof,
	output logic linkup,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input wb_addr_t wb_adr,
	input wb_data_t wb_dat_w,
	output wb_data_t wb_dat_r,
	output logic wb_ack
);

	rx_lane_if lane_bus ();
	stat_if stat_bus ();

	xgmii_rx_align u_align
	(
		.clk (clk),
		.reset_ (reset_),
		.xgmii_rxd (xgmii_rxd),
		.xgmii_rxc (xgmii_rxc),
		.lane (lane_bus.source)
	);

	frame_stats u_stats
	(
		.clk (clk),
		.reset_ (reset_),
		.lane (lane_bus.sink),
		.stats (stat_bus.producer)
	);

	stat_regs u_regs
	(
		.clk (clk),
		.reset_ (reset_),
		.wb_cyc (wb_cyc),
		.wb_stb (wb_stb),
		.wb_we (wb_we),
		.wb_adr (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack (wb_ack),
		.stats (stat_bus.consumer)
	);

	assign rx_data = lane_bus.data;	// aligned stream for observation
	assign rx_ctrl = lane_bus.ctrl;
	assign rx_sof = lane_bus.sof;
	assign linkup = lane_bus.linkup;

endmodule

// ==== rx_mac_checker.sv ====
module rx_mac_checker
	import rx_mac_pkg::*;
(
	input logic clk,
	input logic reset_,
	input xgmii_data_t rx_data,
	input xgmii_ctrl_t rx_ctrl,
	input logic rx_sof,
	input logic linkup,
	input logic wb_ack,
	input wb_data_t wb_dat_r,
	input logic rd_pending,
	input wb_addr_t rd_addr,
	input wb_data_t rd_expect
);

	string test_name = "none";
	int error_cnt = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int test_errs = 0;	// errors in the running test
	int sof_seen = 0;

	task automatic note_failure(input string msg);
		$display("ERROR in %s: %s", test_name, msg);
		error_cnt++;
		test_errs++;
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errs = 0;
		sof_seen = 0;
	endtask

	task automatic end_test(input int exp_sof);
		if (sof_seen != exp_sof)
		begin
			$display("MISMATCH %s rx_sof count expected %0d actual %0d",
				test_name, exp_sof, sof_seen);
			error_cnt++;
			test_errs++;
		end
		tests_run++;
		if (test_errs != 0)
		begin
			tests_failed++;
			$display("test %s failed with %0d errors", test_name, test_errs);
		end
		else
			$display("test %s ok", test_name);
	endtask

	// sample mid-cycle while DUT outputs are stable
	always @(negedge clk)
	begin
		if (reset_)
		begin
			if (rx_sof)
			begin
				sof_seen++;
				if (!rx_ctrl[0] || rx_data[7:0] != XGMII_START)
					note_failure("rx_sof is high but lane 0 holds no start character");
			end
			if (wb_ack && rd_pending && wb_dat_r != rd_expect)
			begin
				$display("MISMATCH %s read addr %0d expected %08h actual %08h",
					test_name, rd_addr, rd_expect, wb_dat_r);
				error_cnt++;
				test_errs++;
			end
			if (wb_ack && rd_pending && rd_addr == REG_STATUS && linkup != rd_expect[0])
			begin
				$display("MISMATCH %s linkup expected %0d actual %0d",
					test_name, rd_expect[0], linkup);
				error_cnt++;
				test_errs++;
			end
		end
	end

endmodule

// ==== tb_rx_mac.sv ====
module tb_rx_mac
	import rx_mac_pkg::*;
();

	localparam int ACK_TIMEOUT = 16;	// cycles

	logic clk;
	logic reset_;
	xgmii_data_t xgmii_rxd;
	xgmii_ctrl_t xgmii_rxc;
	xgmii_data_t rx_data;
	xgmii_ctrl_t rx_ctrl;
	logic rx_sof;
	logic linkup;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	wb_addr_t wb_adr;
	wb_data_t wb_dat_w;
	wb_data_t wb_dat_r;
	logic wb_ack;
	logic rd_pending;	// read waiting for its ack
	wb_data_t rd_expect;
	logic timed_out;
	int fd;
	int code;
	int w_rep;
	int sof_exp;
	string line;
	string cmd;
	string name;
	xgmii_ctrl_t w_ctrl;
	xgmii_data_t w_data;

	rx_mac_top UUT
	(
		.clk (clk),
		.reset_ (reset_),
		.xgmii_rxd (xgmii_rxd),
		.xgmii_rxc (xgmii_rxc),
		.rx_data (rx_data),
		.rx_ctrl (rx_ctrl),
		.rx_sof (rx_sof),
		.linkup (linkup),
		.wb_cyc (wb_cyc),
		.wb_stb (wb_stb),
		.wb_we (wb_we),
		.wb_adr (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack (wb_ack)
	);

	rx_mac_checker u_chk
	(
		.clk (clk),
		.reset_ (reset_),
		.rx_data (rx_data),
		.rx_ctrl (rx_ctrl),
		.rx_sof (rx_sof),
		.linkup (linkup),
		.wb_ack (wb_ack),
		.wb_dat_r (wb_dat_r),
		.rd_pending (rd_pending),
		.rd_addr (wb_adr),
		.rd_expect (rd_expect)
	);

	always #50 clk = ~clk;

	task automatic drive_word(input xgmii_data_t d, input xgmii_ctrl_t c);
		@(posedge clk);
		#5;
		xgmii_rxd = d;
		xgmii_rxc = c;
	endtask

	task automatic wait_ack();
		int n;
		n = 0;
		@(negedge clk);
		while (!wb_ack && n < ACK_TIMEOUT)
		begin
			@(negedge clk);
			n++;
		end
		if (!wb_ack)
		begin
			u_chk.note_failure("no wb_ack came back within the timeout");
			timed_out = 1'b1;
		end
	endtask

	task automatic bus_access(input logic we, input wb_addr_t adr, input wb_data_t dat);
		@(posedge clk);
		#5;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_w = dat;
		rd_pending = !we;
		wait_ack();
		@(posedge clk);
		#5;
		wb_cyc = 1'b0;	// ack has dropped and the bus idles one cycle
		wb_stb = 1'b0;
		wb_we = 1'b0;
		rd_pending = 1'b0;
	endtask

	initial
	begin
		clk = 1'b0;
		reset_ = 1'b0;
		xgmii_rxd = {8{XGMII_IDLE}};
		xgmii_rxc = '1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		rd_pending = 1'b0;
		rd_expect = '0;
		timed_out = 1'b0;
		repeat (2) @(posedge clk);
		#5 reset_ = 1'b1;
		fd = $fopen("rx_mac_stimulus.txt", "r");
		if (fd == 0)
			u_chk.note_failure("cannot open rx_mac_stimulus.txt");
		else
		begin
			while (!timed_out && $fgets(line, fd) > 0)
			begin
				code = $sscanf(line, "%s", cmd);
				if (code == 1 && cmd.getc(0) != "#")	// skip blanks and comments
				begin
					case (cmd)
						"T":
						begin
							code = $sscanf(line, "%s %s", cmd, name);
							u_chk.start_test(name);
						end
						"W":
						begin
							code = $sscanf(line, "%s %h %h %d", cmd, w_ctrl, w_data, w_rep);
							repeat (w_rep) drive_word(w_data, w_ctrl);
						end
						"R":
						begin
							code = $sscanf(line, "%s %h %h", cmd, wb_adr, rd_expect);
							bus_access(1'b0, wb_adr, '0);
						end
						"C": bus_access(1'b1, REG_FRAME_CNT, wb_data_t'(1) << CLEAR_BIT);
						"E":
						begin
							code = $sscanf(line, "%s %d", cmd, sof_exp);
							u_chk.end_test(sof_exp);
						end
						default: u_chk.note_failure({"unknown command in stimulus file: ", cmd});
					endcase
				end
			end
			$fclose(fd);
		end
		$display("tests run %0d, tests failed %0d, errors %0d",
			u_chk.tests_run, u_chk.tests_failed, u_chk.error_cnt);
		if (u_chk.error_cnt != 0 || u_chk.tests_run == 0)
			$display("SIMULATION FAILED");
		else
			$display("SIMULATION PASSED");
		$finish;
	end

endmodule

// ==== rx_mac_stimulus.txt ====
# T name | W ctrl data repeat (hex hex dec) | R addr expected (hex) | C | E rx_sof count
# XGMII words are written with lane 0 in the low byte
T link_up
W ff 0707070707070707 20
R 4 00000001
W 11 0100009c0100009c 1
W ff 0707070707070707 2
R 4 00000000
W 01 d5555555555555fb 1
W 00 1122334455667788 3
W fe 070707070707fd88 1
W ff 0707070707070707 20
R 0 00000000
R 4 00000001
E 1
T lane0_frame
W 01 d5555555555555fb 1
W 00 1122334455667788 9
W fe 070707070707fd88 1
W ff 0707070707070707 4
R 0 00000001
R 2 00000050
R 3 00000000
E 1
T lane4_frame
W 1f 555555fb07070707 1
W 00 11223344d5555555 1
W 00 1122334455667788 8
W e0 0707fd8855667788 1
W ff 0707070707070707 4
R 0 00000002
R 2 000000a0
R 3 00000000
E 1
T short_and_bad_start
W 01 d5555555555555fb 1
W 00 1122334455667788 3
W fe 070707070707fd88 1
W ff 0707070707070707 4
W 07 5555555555fb0707 1
W 00 1122334455667788 3
W fe 070707070707fd88 1
W ff 0707070707070707 4
R 0 00000003
R 1 00000001
R 2 000000c0
R 3 00000001
E 1
T clear_and_unused
C
R 0 00000000
R 1 00000000
R 2 00000000
R 3 00000000
R 7 00000000
R 4 00000001
E 0

// ==== rx_mac_top.f ====
rx_mac_pkg.sv
rx_lane_if.sv
stat_if.sv
xgmii_rx_align.sv
frame_stats.sv
stat_regs.sv
rx_mac_top.sv
rx_mac_checker.sv
tb_rx_mac.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS = --binary --timing -Wno-fatal
TOP = tb_rx_mac
FILELIST = rx_mac_top.f
OBJDIR = obj_dir
SIM = $(OBJDIR)/V$(TOP)
SRCS = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "SIMULATION PASSED"

clean:
	rm -rf $(OBJDIR)
